/* verilog/board_pkg.sv */
//==========================================================
// widths, register map and bus/reset types for the board IO
// GPIO_WIDTH must lie between BUS_WIDTH and 2*BUS_WIDTH
//==========================================================
`default_nettype none

package board_pkg;

	//==========================================================
	// keys and reset requests
	//==========================================================
	localparam int KEY_WIDTH          = 2;  // push keys
	localparam int DEBOUNCE_CYCLES    = 8;  // stable cycles before a level counts
	localparam int RESET_PULSE_CYCLES = 4;  // request length

	//==========================================================
	// GPIO bus and register map
	//==========================================================
	localparam int GPIO_WIDTH = 36;
	localparam int BUS_WIDTH  = 32;
	localparam int ADDR_WIDTH = 3;  // word address
	localparam int NUM_IO_REG = 6;
	localparam int HI_WIDTH   = GPIO_WIDTH - BUS_WIDTH;  // live bits of a high word

	localparam logic [ADDR_WIDTH-1:0] REG_DATA_LO = 3'd0;
	localparam logic [ADDR_WIDTH-1:0] REG_DATA_HI = 3'd1;
	localparam logic [ADDR_WIDTH-1:0] REG_DDR_LO  = 3'd2;  // 1 = output
	localparam logic [ADDR_WIDTH-1:0] REG_DDR_HI  = 3'd3;
	localparam logic [ADDR_WIDTH-1:0] REG_IN_LO   = 3'd4;  // read only
	localparam logic [ADDR_WIDTH-1:0] REG_IN_HI   = 3'd5;

	// one bus operation per cycle
	typedef struct packed {
		logic                  rd;     // single-cycle read strobe
		logic                  wr;     // single-cycle write strobe
		logic [ADDR_WIDTH-1:0] addr;
		logic [BUS_WIDTH-1:0]  wdata;  // only low HI_WIDTH bits matter for high words
	} bus_req_t;

	// processor reset requests, at most one set
	typedef struct packed {
		logic cold;
		logic warm;
		logic debug;
	} reset_req_t;

endpackage

`default_nettype wire

/* verilog/key_debounce.sv */
//==========================================================
// raw keys are active low and asynchronous
// DEBOUNCE_CYCLES must be at least 2
//==========================================================
`timescale 1ns/1ps
`default_nettype none

module key_debounce (
	input  logic                            clk,
	input  logic                            rst,
	input  logic [board_pkg::KEY_WIDTH-1:0] key,          // raw, active low
	output logic [board_pkg::KEY_WIDTH-1:0] key_pressed   // clean, active high
);

	logic [board_pkg::KEY_WIDTH-1:0] key_s;     // sync flop
	logic [board_pkg::KEY_WIDTH-1:0] sampled;   // sampled level as pressed
	logic [$clog2(board_pkg::DEBOUNCE_CYCLES)-1:0] cnt [board_pkg::KEY_WIDTH];

	assign sampled = ~key_s;

	//==========================================================
	// per-key stability counter
	//==========================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			key_s       <= '1;  // released
			key_pressed <= '0;
			for (int i = 0; i < board_pkg::KEY_WIDTH; i++) begin
				cnt[i] <= '0;
			end
		end else begin
			key_s <= key;
			for (int i = 0; i < board_pkg::KEY_WIDTH; i++) begin
				if (sampled[i] == key_pressed[i]) begin
					cnt[i] <= '0;  // nothing pending
				end else if (int'(cnt[i]) == board_pkg::DEBOUNCE_CYCLES - 1) begin
					key_pressed[i] <= sampled[i];  // held long enough
					cnt[i]         <= '0;
				end else begin
					cnt[i] <= cnt[i] + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/reset_req_fsm.sv */
//==========================================================
// key gesture to reset request, one request per gesture
// key 0 = debug, key 1 = warm, both = cold
//==========================================================
`timescale 1ns/1ps
`default_nettype none

module reset_req_fsm (
	input  logic                            clk,
	input  logic                            rst,
	input  logic [board_pkg::KEY_WIDTH-1:0] key_pressed,  // debounced
	output board_pkg::reset_req_t           reset_req
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_COLLECT,  // keys held
		ST_PULSE,    // request out
		ST_RETURN
	} state_t;

	state_t                                          state;
	logic [board_pkg::KEY_WIDTH-1:0]                 mask;       // keys seen this gesture
	logic [$clog2(board_pkg::RESET_PULSE_CYCLES)-1:0] pulse_cnt;
	board_pkg::reset_req_t                           decoded;

	// mask decode, mutually exclusive
	always_comb begin
		decoded.cold  = &mask;
		decoded.warm  = mask[1] & ~mask[0];
		decoded.debug = mask[0] & ~mask[1];
	end

	//==========================================================
	// gesture state machine
	//==========================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= ST_IDLE;
			mask      <= '0;
			pulse_cnt <= '0;
			reset_req <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (|key_pressed) begin
						mask  <= key_pressed;  // gesture starts
						state <= ST_COLLECT;
					end
				end
				ST_COLLECT: begin
					if (|key_pressed) begin
						mask <= mask | key_pressed;
					end else begin
						reset_req <= decoded;  // all released
						pulse_cnt <= '0;
						state     <= ST_PULSE;
					end
				end
				ST_PULSE: begin
					if (int'(pulse_cnt) == board_pkg::RESET_PULSE_CYCLES - 1) begin
						reset_req <= '0;
						state     <= ST_RETURN;
					end else begin
						pulse_cnt <= pulse_cnt + 1'b1;
					end
				end
				ST_RETURN: begin
					mask  <= '0;  // ready for next gesture
					state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* verilog/gpio_reg_bank.sv */
//==========================================================
// six word registers for one GPIO port, no wait states
// rdata is registered and holds until the next read
//==========================================================
`timescale 1ns/1ps
`default_nettype none

module gpio_reg_bank (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             clear,     // warm request
	input  board_pkg::bus_req_t              bus,
	output logic [board_pkg::BUS_WIDTH-1:0]  rdata,
	input  logic [board_pkg::GPIO_WIDTH-1:0] gpio_in,
	output logic [board_pkg::GPIO_WIDTH-1:0] gpio_out,
	output logic [board_pkg::GPIO_WIDTH-1:0] gpio_oe
);

	logic [board_pkg::GPIO_WIDTH-1:0] data_reg;  // output data
	logic [board_pkg::GPIO_WIDTH-1:0] ddr_reg;   // direction, 1 drives
	logic [board_pkg::GPIO_WIDTH-1:0] in_meta;
	logic [board_pkg::GPIO_WIDTH-1:0] in_sync;
	logic                             addr_ok;   // maps to a register
	logic [board_pkg::BUS_WIDTH-1:0]  rd_word;

	assign addr_ok  = int'(bus.addr) < board_pkg::NUM_IO_REG;
	assign gpio_out = data_reg;
	assign gpio_oe  = ddr_reg;

	//==========================================================
	// register write
	//==========================================================
	always_ff @(posedge clk) begin
		if (rst || clear) begin
			data_reg <= '0;  // all inputs
			ddr_reg  <= '0;
		end else if (bus.wr && addr_ok) begin
			case (bus.addr)
				board_pkg::REG_DATA_LO:
					data_reg[board_pkg::BUS_WIDTH-1:0] <= bus.wdata;
				board_pkg::REG_DATA_HI:
					data_reg[board_pkg::GPIO_WIDTH-1:board_pkg::BUS_WIDTH] <=
						bus.wdata[board_pkg::HI_WIDTH-1:0];
				board_pkg::REG_DDR_LO:
					ddr_reg[board_pkg::BUS_WIDTH-1:0] <= bus.wdata;
				board_pkg::REG_DDR_HI:
					ddr_reg[board_pkg::GPIO_WIDTH-1:board_pkg::BUS_WIDTH] <=
						bus.wdata[board_pkg::HI_WIDTH-1:0];
				default: ;  // input words are read only
			endcase
		end
	end

	// two-flop input sync
	always_ff @(posedge clk) begin
		in_meta <= gpio_in;
		in_sync <= in_meta;
	end

	//==========================================================
	// read path
	//==========================================================
	always_comb begin
		rd_word = '0;  // unmapped and unused bits
		if (addr_ok) begin
			case (bus.addr)
				board_pkg::REG_DATA_LO:
					rd_word = data_reg[board_pkg::BUS_WIDTH-1:0];
				board_pkg::REG_DATA_HI:
					rd_word[board_pkg::HI_WIDTH-1:0] =
						data_reg[board_pkg::GPIO_WIDTH-1:board_pkg::BUS_WIDTH];
				board_pkg::REG_DDR_LO:
					rd_word = ddr_reg[board_pkg::BUS_WIDTH-1:0];
				board_pkg::REG_DDR_HI:
					rd_word[board_pkg::HI_WIDTH-1:0] =
						ddr_reg[board_pkg::GPIO_WIDTH-1:board_pkg::BUS_WIDTH];
				board_pkg::REG_IN_LO:
					rd_word = in_sync[board_pkg::BUS_WIDTH-1:0];
				board_pkg::REG_IN_HI:
					rd_word[board_pkg::HI_WIDTH-1:0] =
						in_sync[board_pkg::GPIO_WIDTH-1:board_pkg::BUS_WIDTH];
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rdata <= '0;
		end else if (bus.rd) begin
			rdata <= rd_word;  // valid the cycle after the strobe
		end
	end

endmodule

`default_nettype wire

/* verilog/board_io_top.sv */
//==========================================================
// board IO logic on one clock, keys active low
// a warm request also clears the GPIO port
//==========================================================
`timescale 1ns/1ps
`default_nettype none

module board_io_top (
	input  logic                             clk,
	input  logic                             rst,
	input  logic [board_pkg::KEY_WIDTH-1:0]  key,          // raw, active low
	input  board_pkg::bus_req_t              bus,
	output logic [board_pkg::BUS_WIDTH-1:0]  rdata,
	input  logic [board_pkg::GPIO_WIDTH-1:0] gpio_in,
	output logic [board_pkg::GPIO_WIDTH-1:0] gpio_out,
	output logic [board_pkg::GPIO_WIDTH-1:0] gpio_oe,
	output logic [board_pkg::KEY_WIDTH-1:0]  key_pressed,  // debounced
	output board_pkg::reset_req_t            reset_req
);

	//==========================================================
	// keys to reset requests
	//==========================================================
	key_debounce u_key_debounce (
		.clk         (clk),
		.rst         (rst),
		.key         (key),
		.key_pressed (key_pressed)  // also to the FSM
	);

	reset_req_fsm u_reset_req_fsm (
		.clk         (clk),
		.rst         (rst),
		.key_pressed (key_pressed),
		.reset_req   (reset_req)
	);

	//==========================================================
	// GPIO registers
	//==========================================================
	gpio_reg_bank u_gpio_reg_bank (
		.clk      (clk),
		.rst      (rst),
		.clear    (reset_req.warm),  // warm drops port to inputs
		.bus      (bus),
		.rdata    (rdata),
		.gpio_in  (gpio_in),
		.gpio_out (gpio_out),
		.gpio_oe  (gpio_oe)
	);

endmodule

`default_nettype wire

/* testbench/board_io_assert.sv */
//==========================================================
// request output checks, bound into the gesture FSM
//==========================================================
`timescale 1ns/1ps
`default_nettype none

module board_io_assert (
	input logic                            clk,
	input logic                            rst,
	input logic [board_pkg::KEY_WIDTH-1:0] key_pressed,
	input board_pkg::reset_req_t           reset_req
);

	int high_cnt;  // consecutive cycles with a request

	always_ff @(posedge clk) begin
		if (rst || reset_req == '0) begin
			high_cnt <= 0;
		end else begin
			high_cnt <= high_cnt + 1;
		end
	end

	one_request: assert property (@(posedge clk) disable iff (rst) $onehot0(reset_req))
		else $error("more than one reset request bit high");

	pulse_length: assert property (@(posedge clk) disable iff (rst)
		(reset_req == '0) || (high_cnt < board_pkg::RESET_PULSE_CYCLES))
		else $error("reset request held too long");

	keys_released: assert property (@(posedge clk) disable iff (rst)
		(reset_req != '0) |-> (key_pressed == '0))
		else $error("reset request while a key is pressed");

endmodule

bind reset_req_fsm board_io_assert u_board_io_assert (
	.clk         (clk),
	.rst         (rst),
	.key_pressed (key_pressed),
	.reset_req   (reset_req)
);

`default_nettype wire

/* testbench/tb_board_io.sv */
//==========================================================
// stimulus and expected values come from the stim file
// run from the project root so the stim path resolves
//==========================================================
`timescale 1ns/1ps
`default_nettype none

module tb_board_io;

	localparam int OP_CYCLES = 64;  // longest single stim operation
	localparam int REQ_WAIT  = 32;  // request search window

	logic                             clk;
	logic                             rst;
	logic [board_pkg::KEY_WIDTH-1:0]  key;          // raw active low
	board_pkg::bus_req_t              bus;
	logic [board_pkg::BUS_WIDTH-1:0]  rdata;
	logic [board_pkg::GPIO_WIDTH-1:0] gpio_in;
	logic [board_pkg::GPIO_WIDTH-1:0] gpio_out;
	logic [board_pkg::GPIO_WIDTH-1:0] gpio_oe;
	logic [board_pkg::KEY_WIDTH-1:0]  key_pressed;
	board_pkg::reset_req_t            reset_req;

	int pass_cnt   = 0;
	int fail_cnt   = 0;
	int test_fails = 0;  // since the last test mark
	int cycle      = 0;
	int wd_cycles  = 0;

	// finished request pulses filled by the monitor
	logic [2:0]                      req_val [$];  // cold, warm, debug
	int                              req_len [$];
	int                              req_delay [$];  // release to request
	logic [2:0]                      prev_req    = '0;
	logic [board_pkg::KEY_WIDTH-1:0] prev_kp     = '0;
	int                              release_cyc = 0;
	int                              start_cyc   = 0;
	int                              cur_len     = 0;

	board_io_top UUT (
		.clk         (clk),
		.rst         (rst),
		.key         (key),
		.bus         (bus),
		.rdata       (rdata),
		.gpio_in     (gpio_in),
		.gpio_out    (gpio_out),
		.gpio_oe     (gpio_oe),
		.key_pressed (key_pressed),
		.reset_req   (reset_req)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;  // 100 ns period
	end

	always @(posedge clk) cycle <= cycle + 1;

	//==========================================================
	// request monitor sampling outputs on the falling edge
	//==========================================================
	always @(negedge clk) begin
		if (prev_kp != '0 && key_pressed == '0) begin
			release_cyc = cycle;  // last key let go
		end
		if (reset_req != '0) begin
			if (prev_req == '0) begin
				start_cyc = cycle;
				cur_len   = 0;
			end
			cur_len++;
		end else if (prev_req != '0) begin
			req_val.push_back(prev_req);  // pulse just ended
			req_len.push_back(cur_len);
			req_delay.push_back(start_cyc - release_cyc);
		end
		prev_req = reset_req;
		prev_kp  = key_pressed;
	end

	task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
		assert (got == exp) begin
			pass_cnt++;
		end else begin
			fail_cnt++;
			test_fails++;
			$display("error: %s got %0h expected %0h", name, got, exp);
		end
	endtask

	task automatic check_event(input logic ok, input string what);
		assert (ok) begin
			pass_cnt++;
		end else begin
			fail_cnt++;
			test_fails++;
			$display("%s", what);
		end
	endtask

	//==========================================================
	// stim operations start and end on a falling edge
	//==========================================================
	task automatic bus_write(input logic [63:0] addr, input logic [63:0] data);
		bus.wr    = 1'b1;
		bus.addr  = addr[board_pkg::ADDR_WIDTH-1:0];
		bus.wdata = data[board_pkg::BUS_WIDTH-1:0];
		@(negedge clk);
		bus.wr = 1'b0;
	endtask

	task automatic bus_read(input logic [63:0] addr, input logic [63:0] exp);
		bus.rd   = 1'b1;
		bus.addr = addr[board_pkg::ADDR_WIDTH-1:0];
		@(negedge clk);
		bus.rd = 1'b0;  // rdata holds from here
		check_val($sformatf("rdata at %0h", addr), 64'(rdata), exp);
	endtask

	task automatic set_gpio_in(input logic [63:0] value);
		gpio_in = value[board_pkg::GPIO_WIDTH-1:0];
		repeat (2) @(negedge clk);  // two-flop sync
	endtask

	task automatic check_port(input logic [63:0] exp_out, input logic [63:0] exp_oe);
		check_val("gpio_out", 64'(gpio_out), exp_out);
		check_val("gpio_oe", 64'(gpio_oe), exp_oe);
	endtask

	task automatic hold_keys(input logic [63:0] level, input int cycles,
		input logic [63:0] exp_pressed, input int exp_changes);
		int                              changes;
		logic [board_pkg::KEY_WIDTH-1:0] last;
		changes = 0;
		last    = key_pressed;
		key     = level[board_pkg::KEY_WIDTH-1:0];
		repeat (cycles) begin
			@(negedge clk);
			if (key_pressed != last) begin
				changes++;
			end
			last = key_pressed;
		end
		check_val("key_pressed", 64'(key_pressed), exp_pressed);
		check_val("key_pressed changes", 64'(changes), 64'(exp_changes));
	endtask

	// exp 0 means no request may show up
	task automatic expect_request(input logic [63:0] exp);
		int waited;
		waited = 0;
		if (exp == 0) begin
			repeat (REQ_WAIT) @(posedge clk);
			check_event(req_val.size() == 0, "a reset request appeared without a key gesture");
		end else begin
			while (req_val.size() == 0 && waited < REQ_WAIT) begin
				@(posedge clk);
				waited++;
			end
			check_event(req_val.size() != 0, "no reset request seen after the key release");
		end
		@(negedge clk);
		while (req_val.size() != 0) begin
			check_val("reset_req", 64'(req_val.pop_front()), exp);
			check_val("reset_req length", 64'(req_len.pop_front()),
				64'(board_pkg::RESET_PULSE_CYCLES));
			// cycle after release
			check_val("reset_req delay", 64'(req_delay.pop_front()), 64'd1);
		end
	endtask

	//==========================================================
	// main sequence
	//==========================================================
	initial begin
		int          fd;
		int          n_lines;
		int          cycles;
		int          changes;
		string       line;
		logic [7:0]  op;
		logic [63:0] f1;
		logic [63:0] f2;
		rst     = 1'b1;
		key     = '1;  // released
		bus     = '0;
		gpio_in = '0;
		n_lines = 0;
		fd = $fopen("testbench/board_io_stim.txt", "r");
		if (fd == 0) begin
			fail_cnt++;
			$display("stimulus file testbench/board_io_stim.txt could not be opened");
		end else begin
			while ($fgets(line, fd) != 0) begin
				n_lines++;
			end
			$fclose(fd);
			fd = $fopen("testbench/board_io_stim.txt", "r");
		end
		wd_cycles = (n_lines + 1) * OP_CYCLES + 16;
		repeat (16) @(negedge clk);
		rst = 1'b0;
		while (fd != 0 && $fgets(line, fd) != 0) begin
			if (line.len() < 2 || line.getc(0) == "#") begin
				continue;  // comment or blank
			end
			void'($sscanf(line, "%c %h %h", op, f1, f2));
			case (op)
				"W": bus_write(f1, f2);
				"R": bus_read(f1, f2);
				"G": set_gpio_in(f1);
				"O": check_port(f1, f2);
				"K": begin
					void'($sscanf(line, "%c %h %d %h %d", op, f1, cycles, f2, changes));
					hold_keys(f1, cycles, f2, changes);
				end
				"Q": expect_request(f1);
				"T": begin
					$display("test %0d done, %0d failed checks", f1, test_fails);
					test_fails = 0;
				end
				default: begin
					fail_cnt++;
					$display("unknown stimulus operation in line: %s", line);
				end
			endcase
		end
		if (fd != 0) begin
			$fclose(fd);
		end
		$display("checks passed %0d failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// watchdog sized from the stim line count
	initial begin
		wait (wd_cycles > 0);
		repeat (wd_cycles) @(posedge clk);
		$display("watchdog expired after %0d cycles, run did not complete", wd_cycles);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* testbench/board_io_stim.txt */
# W addr data | R addr expect | G gpio_in | O gpio_out gpio_oe | T test number (all hex)
# K raw_key hold_cycles(dec) key_pressed changes(dec) | Q request 4 cold 2 warm 1 debug 0 none
W 0 a5a55a5a
W 1 fffffffc
W 2 12345678
W 3 00000009
O ca5a55a5a 912345678
R 0 a5a55a5a
R 1 0000000c
R 2 12345678
R 3 00000009
T 1
G 5deadbeef
R 4 deadbeef
R 5 00000005
T 2
W 4 ffffffff
W 5 ffffffff
W 6 ffffffff
W 7 ffffffff
R 6 00000000
R 7 00000000
R 0 a5a55a5a
R 1 0000000c
R 2 12345678
R 3 00000009
R 4 deadbeef
R 5 00000005
T 3
K 2 5 0 0
K 3 20 0 0
Q 0
K 2 12 1 1
K 3 12 0 1
Q 1
O ca5a55a5a 912345678
T 4
K 2 12 1 1
K 0 12 3 1
K 1 12 2 1
K 3 12 0 1
Q 4
O ca5a55a5a 912345678
T 5
K 1 12 2 1
K 3 12 0 1
Q 2
O 0 0
R 0 00000000
R 1 00000000
R 2 00000000
R 3 00000000
T 6

/* sources.f */
verilog/board_pkg.sv
verilog/key_debounce.sv
verilog/reset_req_fsm.sv
verilog/gpio_reg_bank.sv
verilog/board_io_top.sv
testbench/board_io_assert.sv
testbench/tb_board_io.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Verilator build and run of tb_board_io, from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f sources.f --top-module tb_board_io -Mdir obj_dir \
	&& ./obj_dir/Vtb_board_io > sim.log 2>&1 \
	|| echo "build or simulation did not finish cleanly"

cat sim.log 2>/dev/null

grep -qx "TEST PASSED" sim.log && echo "simulation passed" && exit 0 \
	|| { echo "simulation failed"; exit 1; }
